// ==== all.f ====
+incdir+design
design/ps2_frame_pkg.sv
design/mouse_reg_pkg.sv
design/ps2_line_sync.sv
design/ps2_tx.sv
design/ps2_rx.sv
design/mouse_packet_assembler.sv
design/mouse_axi_regs.sv
design/ps2_mouse_host.sv
bench/mouse_device_model.sv
bench/tb_ps2_mouse_host.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ps2_mouse_host
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
LOG       ?= run.log
FAIL_MSG  ?= Test failures found
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_ps2_mouse_host.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ps2_mouse_settings.svh"

module tb_ps2_mouse_host;

  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  logic                     MOUSE_CLOCK = 1'b0;
  logic                     rst_n;
  wire                      ps2_clk;
  wire                      ps2_data;
  logic [`MOUSE_ADDR_W-1:0] awaddr;
  logic                     awvalid;
  wire                      awready;
  logic [31:0]              wdata;
  logic [3:0]               wstrb;
  logic                     wvalid;
  wire                      wready;
  wire  [1:0]               bresp;
  wire                      bvalid;
  logic                     bready;
  logic [`MOUSE_ADDR_W-1:0] araddr;
  logic                     arvalid;
  wire                      arready;
  wire  [31:0]              rdata;
  wire  [1:0]               rresp;
  wire                      rvalid;
  logic                     rready;

  int          errors   = 0;
  int          timeouts = 0;
  logic [31:0] lfsr;
  logic [31:0] last_pkt;

  always #10 MOUSE_CLOCK = ~MOUSE_CLOCK;

  pullup (ps2_clk);
  pullup (ps2_data);

  ps2_mouse_host dut_i (
    .MOUSE_CLOCK(MOUSE_CLOCK), .rst_n(rst_n), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  mouse_device_model dev_i (.MOUSE_CLOCK(MOUSE_CLOCK), .ps2_clk(ps2_clk), .ps2_data(ps2_data));

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1.
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out at %0t waiting for %s", $time, what);
    timeouts++;
  endtask

  task automatic axi_write(input logic [`MOUSE_ADDR_W-1:0] addr, input logic [31:0] data,
                           input int stall, output logic [1:0] resp);
    int n;
    @(posedge MOUSE_CLOCK);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= 4'hf;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    n = 0;
    do begin
      @(negedge MOUSE_CLOCK);
      n++;
    end while (!(awready && wready) && n < 100);
    assert (awready && wready) else report_timeout("awready and wready");
    @(posedge MOUSE_CLOCK);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    n = 0;
    do begin
      @(negedge MOUSE_CLOCK);
      n++;
    end while (!bvalid && n < 100);
    assert (bvalid) else report_timeout("bvalid");
    resp = bresp;
    repeat (stall) begin
      @(negedge MOUSE_CLOCK);
      assert (bvalid === 1'b1 && bresp === resp) else begin
        $display("write response dropped or changed while bready was low at %0t", $time);
        errors++;
      end
    end
    @(posedge MOUSE_CLOCK);
    bready <= 1'b1;
    @(posedge MOUSE_CLOCK);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [`MOUSE_ADDR_W-1:0] addr, input int stall,
                          output logic [31:0] data, output logic [1:0] resp);
    int n;
    @(posedge MOUSE_CLOCK);
    araddr  <= addr;
    arvalid <= 1'b1;
    n = 0;
    do begin
      @(negedge MOUSE_CLOCK);
      n++;
    end while (!arready && n < 100);
    assert (arready) else report_timeout("arready");
    @(posedge MOUSE_CLOCK);
    arvalid <= 1'b0;
    n = 0;
    do begin
      @(negedge MOUSE_CLOCK);
      n++;
    end while (!rvalid && n < 100);
    assert (rvalid) else report_timeout("rvalid");
    data = rdata;
    resp = rresp;
    repeat (stall) begin
      @(negedge MOUSE_CLOCK);
      assert (rvalid === 1'b1 && rdata === data && rresp === resp) else begin
        $display("read response dropped or changed while rready was low at %0t", $time);
        errors++;
      end
    end
    @(posedge MOUSE_CLOCK);
    rready <= 1'b1;
    @(posedge MOUSE_CLOCK);
    rready <= 1'b0;
  endtask

  task automatic wait_status(input int idx, input logic val, input string what,
                             output logic [31:0] d);
    logic [1:0] r;
    int         n;
    n = 0;
    do begin
      axi_read(mouse_reg_pkg::REG_STATUS, 0, d, r);
      n++;
    end while (d[idx] !== val && n < 2000);
    assert (d[idx] === val) else report_timeout(what);
  endtask

  task automatic send_packet(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2);
    dev_i.send_byte(b0, 1'b0);
    dev_i.send_byte(b1, 1'b0);
    dev_i.send_byte(b2, 1'b0);
  endtask

  // packet, motion and status fields all follow from the three raw bytes.
  task automatic check_packet(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2);
    logic [31:0] d;
    logic [1:0]  r;
    wait_status(mouse_reg_pkg::PKT_VALID, 1'b1, "PKT_VALID", d);
    expect_eq("status[9:5]", d[mouse_reg_pkg::Y_OVF:mouse_reg_pkg::BTN_LSB],
              {b0[7], b0[6], b0[2:0]});
    axi_read(mouse_reg_pkg::REG_PACKET, 0, d, r);
    expect_eq("packet", d, {8'h00, b0, b1, b2});
    expect_eq("packet rresp", r, OKAY);
    last_pkt = {8'h00, b0, b1, b2};
    axi_read(mouse_reg_pkg::REG_MOTION, 0, d, r);
    expect_eq("motion", d, {{8{b0[5]}}, b2, {8{b0[4]}}, b1});
    axi_read(mouse_reg_pkg::REG_STATUS, 0, d, r);
    expect_eq("status.pkt_valid", d[mouse_reg_pkg::PKT_VALID], 1'b0);
  endtask

  task automatic check_reset();
    logic [31:0] d;
    logic [1:0]  r;
    expect_eq("awready", awready, 1'b0);
    expect_eq("wready", wready, 1'b0);
    expect_eq("arready", arready, 1'b0);
    expect_eq("bvalid", bvalid, 1'b0);
    expect_eq("rvalid", rvalid, 1'b0);
    axi_read(mouse_reg_pkg::REG_STATUS, 0, d, r);
    expect_eq("status", d, 32'h0);
    expect_eq("status rresp", r, OKAY);
    axi_read(4'h6, 0, d, r);  // no register at this offset.
    expect_eq("unmapped rresp", r, SLVERR);
  endtask

  task automatic check_command();
    logic [31:0] d;
    logic [1:0]  r;
    logic [7:0]  cmd;
    logic        par_ok;
    logic        ok;
    axi_write(mouse_reg_pkg::REG_CMD_RESP, 32'hf4, 0, r);
    expect_eq("cmd bresp", r, OKAY);
    fork
      dev_i.recv_cmd(cmd, par_ok, ok);
      begin
        repeat (20) @(posedge MOUSE_CLOCK);
        axi_read(mouse_reg_pkg::REG_STATUS, 0, d, r);
        expect_eq("status.tx_busy", d[mouse_reg_pkg::TX_BUSY], 1'b1);
        axi_write(mouse_reg_pkg::REG_CMD_RESP, 32'hff, 0, r);
        expect_eq("busy cmd bresp", r, SLVERR);
      end
    join
    assert (ok) else begin
      $display("device model saw no complete command frame");
      errors++;
    end
    expect_eq("command byte", cmd, 8'hf4);
    expect_eq("command parity ok", par_ok, 1'b1);
    wait_status(mouse_reg_pkg::TX_BUSY, 1'b0, "TX_BUSY to clear", d);
    expect_eq("status.tx_err", d[mouse_reg_pkg::TX_ERR], 1'b0);
    dev_i.send_byte(8'hfa, 1'b0);
    wait_status(mouse_reg_pkg::RESP_VALID, 1'b1, "RESP_VALID", d);
    axi_read(mouse_reg_pkg::REG_CMD_RESP, 0, d, r);
    expect_eq("cmd_resp", d, 32'hfa);
    axi_read(mouse_reg_pkg::REG_STATUS, 0, d, r);
    expect_eq("status.resp_valid", d[mouse_reg_pkg::RESP_VALID], 1'b0);
  endtask

  task automatic check_packets();
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    rand_byte(b0);
    rand_byte(b1);
    rand_byte(b2);
    b0[3] = 1'b1;
    send_packet(b0, b1, b2);
    check_packet(b0, b1, b2);
  endtask

  task automatic check_parity_error();
    logic [31:0] d;
    logic [1:0]  r;
    logic [7:0]  b;
    logic [7:0]  tail0;
    logic [7:0]  tail1;
    rand_byte(b);
    rand_byte(tail0);
    rand_byte(tail1);
    tail0[3] = 1'b0;  // only completes a packet if the bad byte was kept.
    tail1[3] = 1'b0;
    dev_i.send_byte(b | 8'h08, 1'b1);
    wait_status(mouse_reg_pkg::RX_ERR, 1'b1, "RX_ERR", d);
    dev_i.send_byte(tail0, 1'b0);
    dev_i.send_byte(tail1, 1'b0);
    axi_read(mouse_reg_pkg::REG_STATUS, 0, d, r);
    expect_eq("status.pkt_valid", d[mouse_reg_pkg::PKT_VALID], 1'b0);
    axi_write(mouse_reg_pkg::REG_STATUS, 32'hffff_ffff, 0, r);
    expect_eq("status bresp", r, OKAY);
    axi_read(mouse_reg_pkg::REG_STATUS, 0, d, r);
    expect_eq("status.rx_err", d[mouse_reg_pkg::RX_ERR], 1'b0);
  endtask

  task automatic check_resync();
    logic [7:0] stray;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    rand_byte(stray);
    rand_byte(b0);
    rand_byte(b1);
    rand_byte(b2);
    stray[3] = 1'b0;
    b0[3]    = 1'b1;
    dev_i.send_byte(stray, 1'b0);
    send_packet(b0, b1, b2);
    check_packet(b0, b1, b2);
  endtask

  task automatic check_backpressure();
    logic [31:0] d;
    logic [1:0]  r;
    axi_write(mouse_reg_pkg::REG_STATUS, 32'h0, 20, r);
    expect_eq("stalled bresp", r, OKAY);
    axi_read(mouse_reg_pkg::REG_PACKET, 20, d, r);
    expect_eq("stalled packet", d, last_pkt);
    expect_eq("stalled rresp", r, OKAY);
  endtask

  initial begin
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    lfsr    = 32'hf166;
    last_pkt = '0;
    repeat (10) @(posedge MOUSE_CLOCK);
    rst_n <= 1'b1;
    @(posedge MOUSE_CLOCK);
    check_reset();
    check_command();
    check_packets();
    check_parity_error();
    check_resync();
    check_backpressure();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/mouse_device_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module mouse_device_model #(
  parameter int HALF_CYCLES = 30
) (
  input wire MOUSE_CLOCK,
  inout wire ps2_clk,
  inout wire ps2_data
);

  logic clk_low;
  logic data_low;

  assign ps2_clk  = clk_low ? 1'b0 : 1'bz;
  assign ps2_data = data_low ? 1'b0 : 1'bz;

  initial begin
    clk_low  = 1'b0;
    data_low = 1'b0;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge MOUSE_CLOCK);
  endtask

  // one 60 cycle device clock, data read back as the clock rises.
  task automatic clock_pulse(output logic sampled);
    wait_cycles(HALF_CYCLES / 2);
    clk_low <= 1'b1;
    wait_cycles(HALF_CYCLES);
    clk_low <= 1'b0;
    sampled = ps2_data;
    wait_cycles(HALF_CYCLES / 2);
  endtask

  task automatic send_byte(input logic [7:0] b, input logic bad_parity);
    logic [10:0] frame;
    logic        ignored;
    frame = {1'b1, (~^b) ^ bad_parity, b, 1'b0};  // stop, odd parity, data, start.
    for (int i = 0; i < 11; i++) begin
      data_low <= ~frame[i];
      clock_pulse(ignored);
    end
    wait_cycles(HALF_CYCLES);
  endtask

  task automatic recv_cmd(output logic [7:0] b, output logic par_ok, output logic ok);
    logic [9:0] bits;
    logic       ignored;
    int         n;
    b      = '0;
    par_ok = 1'b0;
    ok     = 1'b0;
    n      = 0;
    while (ps2_clk !== 1'b0 && n < 1000) begin  // host inhibit.
      @(posedge MOUSE_CLOCK);
      n++;
    end
    if (ps2_clk !== 1'b0)
      return;
    n = 0;
    while (!(ps2_clk === 1'b1 && ps2_data === 1'b0) && n < 1000) begin
      @(posedge MOUSE_CLOCK);
      n++;
    end
    if (ps2_data !== 1'b0)
      return;
    for (int i = 0; i < 10; i++)
      clock_pulse(bits[i]);
    data_low <= 1'b1;  // acknowledge on the 11th clock.
    clock_pulse(ignored);
    data_low <= 1'b0;
    b      = bits[7:0];
    par_ok = ^bits[8:0];
    ok     = bits[9];
  endtask

endmodule

`default_nettype wire

// ==== design/ps2_mouse_host.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ps2_mouse_settings.svh"

module ps2_mouse_host (
  input  wire                      MOUSE_CLOCK,
  input  wire                      rst_n,
  inout  wire                      ps2_clk,
  inout  wire                      ps2_data,
  input  wire  [`MOUSE_ADDR_W-1:0] awaddr,
  input  wire                      awvalid,
  output logic                     awready,
  input  wire  [31:0]              wdata,
  input  wire  [3:0]               wstrb,
  input  wire                      wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  wire                      bready,
  input  wire  [`MOUSE_ADDR_W-1:0] araddr,
  input  wire                      arvalid,
  output logic                     arready,
  output logic [31:0]              rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  wire                      rready
);

  logic clk_fall, data_s;
  logic tx_busy, clk_oe, data_oe, tx_done, tx_ack_err, tx_ok;
  logic rx_valid, rx_err, resp_valid, pkt_valid, cmd_start;
  logic [7:0] rx_byte, resp_byte, cmd_byte;
  mouse_reg_pkg::mouse_packet_u pkt;

  // open drain, pull low or release.
  assign ps2_clk  = clk_oe ? 1'b0 : 1'bz;
  assign ps2_data = data_oe ? 1'b0 : 1'bz;
  assign tx_ok    = tx_done && !tx_ack_err;  // no reply follows a nack.

  ps2_line_sync sync_i (
    .MOUSE_CLOCK(MOUSE_CLOCK), .rst_n(rst_n), .ps2_clk_in(ps2_clk), .ps2_data_in(ps2_data),
    .clk_fall(clk_fall), .data_s(data_s)
  );

  ps2_tx tx_i (
    .MOUSE_CLOCK(MOUSE_CLOCK), .rst_n(rst_n), .cmd_start(cmd_start), .cmd_byte(cmd_byte),
    .clk_fall(clk_fall), .data_s(data_s), .tx_busy(tx_busy), .clk_oe(clk_oe),
    .data_oe(data_oe), .tx_done(tx_done), .tx_ack_err(tx_ack_err)
  );

  ps2_rx rx_i (
    .MOUSE_CLOCK(MOUSE_CLOCK), .rst_n(rst_n), .clk_fall(clk_fall), .data_s(data_s),
    .tx_busy(tx_busy), .rx_valid(rx_valid), .rx_byte(rx_byte), .rx_err(rx_err)
  );

  mouse_packet_assembler asm_i (
    .MOUSE_CLOCK(MOUSE_CLOCK), .rst_n(rst_n), .tx_done(tx_ok), .rx_valid(rx_valid),
    .rx_byte(rx_byte), .resp_valid(resp_valid), .resp_byte(resp_byte),
    .pkt_valid(pkt_valid), .pkt(pkt)
  );

  mouse_axi_regs regs_i (
    .MOUSE_CLOCK(MOUSE_CLOCK), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .tx_busy(tx_busy), .tx_done(tx_done), .tx_ack_err(tx_ack_err), .rx_err(rx_err),
    .resp_valid(resp_valid), .resp_byte(resp_byte), .pkt_valid(pkt_valid), .pkt(pkt),
    .cmd_start(cmd_start), .cmd_byte(cmd_byte)
  );

endmodule

`default_nettype wire

// ==== design/mouse_axi_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ps2_mouse_settings.svh"

module mouse_axi_regs (
  input  wire                              MOUSE_CLOCK,
  input  wire                              rst_n,
  input  wire  [`MOUSE_ADDR_W-1:0]         awaddr,
  input  wire                              awvalid,
  output logic                             awready,
  input  wire  [31:0]                      wdata,
  input  wire  [3:0]                       wstrb,
  input  wire                              wvalid,
  output logic                             wready,
  output logic [1:0]                       bresp,
  output logic                             bvalid,
  input  wire                              bready,
  input  wire  [`MOUSE_ADDR_W-1:0]         araddr,
  input  wire                              arvalid,
  output logic                             arready,
  output logic [31:0]                      rdata,
  output logic [1:0]                       rresp,
  output logic                             rvalid,
  input  wire                              rready,
  input  wire                              tx_busy,
  input  wire                              tx_done,
  input  wire                              tx_ack_err,
  input  wire                              rx_err,
  input  wire                              resp_valid,
  input  wire  [7:0]                       resp_byte,
  input  wire                              pkt_valid,
  input  wire  mouse_reg_pkg::mouse_packet_u pkt,
  output logic                             cmd_start,
  output logic [7:0]                       cmd_byte
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  mouse_reg_pkg::mouse_packet_u pkt_q;
  logic [7:0]  resp_q;
  logic        pkt_flag;
  logic        resp_flag;
  logic        tx_err_flag;
  logic        rx_err_flag;
  logic        wr_en;
  logic        rd_en;
  logic        cmd_busy;
  logic        wr_mapped;
  logic        rd_mapped;
  logic        wr_status;
  logic        wr_cmd;
  logic        rd_pkt;
  logic        rd_resp;
  logic [31:0] status_w;
  logic [31:0] motion_w;

  assign wr_en    = awvalid && wvalid && !bvalid;
  assign rd_en    = arvalid && !rvalid;
  assign awready  = wr_en;
  assign wready   = wr_en;
  assign arready  = rd_en;
  assign cmd_busy = tx_busy || cmd_start;  // tx sees the start one cycle late.

  assign wr_mapped = awaddr inside {mouse_reg_pkg::REG_STATUS, mouse_reg_pkg::REG_PACKET,
                                    mouse_reg_pkg::REG_MOTION, mouse_reg_pkg::REG_CMD_RESP};
  assign rd_mapped = araddr inside {mouse_reg_pkg::REG_STATUS, mouse_reg_pkg::REG_PACKET,
                                    mouse_reg_pkg::REG_MOTION, mouse_reg_pkg::REG_CMD_RESP};

  assign wr_status = wr_en && wstrb[0] && (awaddr == mouse_reg_pkg::REG_STATUS);
  assign wr_cmd    = wr_en && wstrb[0] && !cmd_busy && (awaddr == mouse_reg_pkg::REG_CMD_RESP);
  assign rd_pkt    = rd_en && (araddr == mouse_reg_pkg::REG_PACKET ||
                               araddr == mouse_reg_pkg::REG_MOTION);
  assign rd_resp   = rd_en && (araddr == mouse_reg_pkg::REG_CMD_RESP);

  always_comb begin
    status_w = '0;
    status_w[mouse_reg_pkg::PKT_VALID]  = pkt_flag;
    status_w[mouse_reg_pkg::RESP_VALID] = resp_flag;
    status_w[mouse_reg_pkg::TX_BUSY]    = cmd_busy;
    status_w[mouse_reg_pkg::TX_ERR]     = tx_err_flag;
    status_w[mouse_reg_pkg::RX_ERR]     = rx_err_flag;
    status_w[mouse_reg_pkg::BTN_MSB:mouse_reg_pkg::BTN_LSB] =
      {pkt_q.mot.middle, pkt_q.mot.right, pkt_q.mot.left};
    status_w[mouse_reg_pkg::X_OVF] = pkt_q.mot.x_ovf;
    status_w[mouse_reg_pkg::Y_OVF] = pkt_q.mot.y_ovf;
  end

  // 9-bit two's complement deltas, sign-extended.
  assign motion_w = {{8{pkt_q.mot.y_sign}}, pkt_q.mot.y, {8{pkt_q.mot.x_sign}}, pkt_q.mot.x};

  always_ff @(posedge MOUSE_CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      bvalid      <= 1'b0;
      bresp       <= RESP_OKAY;
      rvalid      <= 1'b0;
      rresp       <= RESP_OKAY;
      rdata       <= '0;
      cmd_start   <= 1'b0;
      pkt_flag    <= 1'b0;
      resp_flag   <= 1'b0;
      tx_err_flag <= 1'b0;
      rx_err_flag <= 1'b0;
      pkt_q       <= '0;
      resp_q      <= '0;
    end else begin
      cmd_start <= wr_cmd;
      if (wr_en) begin
        bvalid <= 1'b1;
        if (!wr_mapped || (awaddr == mouse_reg_pkg::REG_CMD_RESP && cmd_busy))
          bresp <= RESP_SLVERR;
        else
          bresp <= RESP_OKAY;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_en) begin
        rvalid <= 1'b1;
        rresp  <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
        case (araddr)
          mouse_reg_pkg::REG_STATUS:   rdata <= status_w;
          mouse_reg_pkg::REG_PACKET:   rdata <= {8'h00, pkt_q.raw};
          mouse_reg_pkg::REG_MOTION:   rdata <= motion_w;
          mouse_reg_pkg::REG_CMD_RESP: rdata <= {24'h0, resp_q};
          default:                     rdata <= '0;
        endcase
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      // new events win over a clear in the same cycle.
      if (pkt_valid) begin
        pkt_flag <= 1'b1;
        pkt_q    <= pkt;
      end else if (rd_pkt) begin
        pkt_flag <= 1'b0;
      end
      if (resp_valid) begin
        resp_flag <= 1'b1;
        resp_q    <= resp_byte;
      end else if (rd_resp) begin
        resp_flag <= 1'b0;
      end
      if (tx_done && tx_ack_err)
        tx_err_flag <= 1'b1;
      else if (wr_status && wdata[mouse_reg_pkg::TX_ERR])
        tx_err_flag <= 1'b0;
      if (rx_err)
        rx_err_flag <= 1'b1;
      else if (wr_status && wdata[mouse_reg_pkg::RX_ERR])
        rx_err_flag <= 1'b0;
    end
  end

  always_ff @(posedge MOUSE_CLOCK) begin
    if (wr_cmd)
      cmd_byte <= wdata[7:0];
  end

  a_b_hold: assert property (@(posedge MOUSE_CLOCK) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

  a_r_hold: assert property (@(posedge MOUSE_CLOCK) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// ==== design/mouse_packet_assembler.sv ====
`timescale 1ns/10ps
`default_nettype none

module mouse_packet_assembler (
  input  wire                         MOUSE_CLOCK,
  input  wire                         rst_n,
  input  wire                         tx_done,
  input  wire                         rx_valid,
  input  wire  [7:0]                  rx_byte,
  output logic                        resp_valid,
  output logic [7:0]                  resp_byte,
  output logic                        pkt_valid,
  output mouse_reg_pkg::mouse_packet_u pkt
);

  logic       expect_resp;
  logic [1:0] idx;
  logic [7:0] byte0;
  logic [7:0] byte1;

  always_ff @(posedge MOUSE_CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      expect_resp <= 1'b0;
      idx         <= '0;
      resp_valid  <= 1'b0;
      pkt_valid   <= 1'b0;
    end else begin
      resp_valid <= 1'b0;
      pkt_valid  <= 1'b0;
      if (tx_done) begin
        expect_resp <= 1'b1;
        idx         <= '0;  // command breaks the stream.
      end else if (rx_valid) begin
        if (expect_resp) begin
          expect_resp <= 1'b0;
          resp_valid  <= 1'b1;
        end else begin
          case (idx)
            2'd0: if (rx_byte[3]) idx <= 2'd1;  // drop bytes out of step.
            2'd1: idx <= 2'd2;
            default: begin
              idx       <= 2'd0;
              pkt_valid <= 1'b1;
            end
          endcase
        end
      end
    end
  end

  always_ff @(posedge MOUSE_CLOCK) begin
    if (rx_valid && !tx_done) begin
      if (expect_resp) begin
        resp_byte <= rx_byte;
      end else begin
        case (idx)
          2'd0: byte0 <= rx_byte;
          2'd1: byte1 <= rx_byte;
          default: begin
            pkt.raw.byte0 <= byte0;
            pkt.raw.byte1 <= byte1;
            pkt.raw.byte2 <= rx_byte;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/ps2_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ps2_mouse_settings.svh"

module ps2_rx (
  input  wire        MOUSE_CLOCK,
  input  wire        rst_n,
  input  wire        clk_fall,
  input  wire        data_s,
  input  wire        tx_busy,
  output logic       rx_valid,
  output logic [7:0] rx_byte,
  output logic       rx_err
);

  localparam int WD_W = $clog2(`PS2_TIMEOUT_CYCLES + 1);

  ps2_frame_pkg::rx_state_t state;
  logic [7:0]      shreg;
  logic [2:0]      bit_cnt;
  logic            par_ok;
  logic [WD_W-1:0] wd_cnt;
  logic            stall;

  assign stall   = (state != ps2_frame_pkg::RX_IDLE) && (wd_cnt == WD_W'(`PS2_TIMEOUT_CYCLES));
  assign rx_byte = shreg;

  always_ff @(posedge MOUSE_CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ps2_frame_pkg::RX_IDLE;
      bit_cnt  <= '0;
      par_ok   <= 1'b0;
      wd_cnt   <= '0;
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
      if (tx_busy) begin  // host owns the lines.
        state  <= ps2_frame_pkg::RX_IDLE;
        wd_cnt <= '0;
      end else if (stall) begin
        state  <= ps2_frame_pkg::RX_IDLE;
        rx_err <= 1'b1;
      end else begin
        if (clk_fall || state == ps2_frame_pkg::RX_IDLE)
          wd_cnt <= '0;
        else
          wd_cnt <= wd_cnt + 1'b1;
        if (clk_fall) begin
          case (state)
            ps2_frame_pkg::RX_IDLE: if (!data_s) begin
              state   <= ps2_frame_pkg::RX_DATA;
              bit_cnt <= '0;
            end
            ps2_frame_pkg::RX_DATA: begin
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == 3'd7)
                state <= ps2_frame_pkg::RX_PARITY;
            end
            ps2_frame_pkg::RX_PARITY: begin
              par_ok <= ^{shreg, data_s};  // odd parity.
              state  <= ps2_frame_pkg::RX_STOP;
            end
            default: begin
              state <= ps2_frame_pkg::RX_IDLE;
              if (data_s && par_ok)
                rx_valid <= 1'b1;
              else
                rx_err <= 1'b1;
            end
          endcase
        end
      end
    end
  end

  // lsb arrives first.
  always_ff @(posedge MOUSE_CLOCK) begin
    if (clk_fall && !tx_busy && state == ps2_frame_pkg::RX_DATA)
      shreg <= {data_s, shreg[7:1]};
  end

  a_valid_xor_err: assert property (@(posedge MOUSE_CLOCK) disable iff (!rst_n)
    !(rx_valid && rx_err));

endmodule

`default_nettype wire

// ==== design/ps2_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ps2_mouse_settings.svh"

module ps2_tx (
  input  wire        MOUSE_CLOCK,
  input  wire        rst_n,
  input  wire        cmd_start,
  input  wire  [7:0] cmd_byte,
  input  wire        clk_fall,
  input  wire        data_s,
  output logic       tx_busy,
  output logic       clk_oe,
  output logic       data_oe,
  output logic       tx_done,
  output logic       tx_ack_err
);

  localparam int INH_W = $clog2(`PS2_INHIBIT_CYCLES);
  localparam int WD_W  = $clog2(`PS2_TIMEOUT_CYCLES + 1);

  ps2_frame_pkg::tx_state_t state;
  logic [INH_W-1:0] inh_cnt;
  logic [WD_W-1:0]  wd_cnt;
  logic [7:0]       shreg;
  logic [2:0]       bit_cnt;
  logic             parity;
  logic             ack_ok;
  logic             timeout;

  assign tx_busy = (state != ps2_frame_pkg::TX_IDLE);
  assign clk_oe  = (state == ps2_frame_pkg::TX_INHIBIT);
  assign timeout = tx_busy && !clk_oe && (wd_cnt == WD_W'(`PS2_TIMEOUT_CYCLES));

  always_comb begin
    case (state)
      ps2_frame_pkg::TX_START:  data_oe = 1'b1;
      ps2_frame_pkg::TX_DATA:   data_oe = ~shreg[0];
      ps2_frame_pkg::TX_PARITY: data_oe = ~parity;
      default:                  data_oe = 1'b0;  // stop and ack leave data released.
    endcase
  end

  always_ff @(posedge MOUSE_CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ps2_frame_pkg::TX_IDLE;
      inh_cnt    <= '0;
      wd_cnt     <= '0;
      bit_cnt    <= '0;
      ack_ok     <= 1'b0;
      tx_done    <= 1'b0;
      tx_ack_err <= 1'b0;
    end else begin
      tx_done    <= 1'b0;
      tx_ack_err <= 1'b0;
      if (clk_fall || !tx_busy || clk_oe)
        wd_cnt <= '0;
      else
        wd_cnt <= wd_cnt + 1'b1;
      if (timeout) begin
        state      <= ps2_frame_pkg::TX_IDLE;
        tx_done    <= 1'b1;
        tx_ack_err <= 1'b1;
      end else begin
        case (state)
          ps2_frame_pkg::TX_IDLE: if (cmd_start) begin
            state   <= ps2_frame_pkg::TX_INHIBIT;
            inh_cnt <= INH_W'(`PS2_INHIBIT_CYCLES - 1);
          end
          ps2_frame_pkg::TX_INHIBIT: begin
            inh_cnt <= inh_cnt - 1'b1;
            if (inh_cnt == '0)
              state <= ps2_frame_pkg::TX_START;
          end
          ps2_frame_pkg::TX_START: if (clk_fall) begin
            state   <= ps2_frame_pkg::TX_DATA;
            bit_cnt <= '0;
          end
          ps2_frame_pkg::TX_DATA: if (clk_fall) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
              state <= ps2_frame_pkg::TX_PARITY;
          end
          ps2_frame_pkg::TX_PARITY: if (clk_fall)
            state <= ps2_frame_pkg::TX_STOP;
          ps2_frame_pkg::TX_STOP: if (clk_fall) begin
            ack_ok <= ~data_s;  // device pulls data low on the 11th edge.
            state  <= ps2_frame_pkg::TX_ACK;
          end
          default: if (data_s) begin  // wait for the device to let go.
            state      <= ps2_frame_pkg::TX_IDLE;
            tx_done    <= 1'b1;
            tx_ack_err <= ~ack_ok;
          end
        endcase
      end
    end
  end

  always_ff @(posedge MOUSE_CLOCK) begin
    if (cmd_start && !tx_busy) begin
      shreg  <= cmd_byte;
      parity <= ~^cmd_byte;
    end else if (state == ps2_frame_pkg::TX_DATA && clk_fall && bit_cnt != 3'd7) begin
      shreg <= shreg >> 1;
    end
  end

  a_idle_quiet: assert property (@(posedge MOUSE_CLOCK) disable iff (!rst_n)
    (state == ps2_frame_pkg::TX_IDLE) |-> !(clk_oe || data_oe));

  a_done_source: assert property (@(posedge MOUSE_CLOCK) disable iff (!rst_n)
    $rose(tx_done) |-> $past(state == ps2_frame_pkg::TX_ACK || timeout));

endmodule

`default_nettype wire

// ==== design/ps2_line_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_line_sync (
  input  wire  MOUSE_CLOCK,
  input  wire  rst_n,
  input  wire  ps2_clk_in,
  input  wire  ps2_data_in,
  output logic clk_fall,
  output logic data_s
);

  logic [1:0] clk_sync;
  logic [1:0] data_sync;
  logic       clk_prev;

  // both lines idle high.
  always_ff @(posedge MOUSE_CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
      clk_fall  <= 1'b0;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk_in};
      data_sync <= {data_sync[0], ps2_data_in};
      clk_prev  <= clk_sync[1];
      clk_fall  <= clk_prev & ~clk_sync[1];  // third cycle after the pad edge.
    end
  end

  assign data_s = data_sync[1];

endmodule

`default_nettype wire

// ==== design/mouse_reg_pkg.sv ====
`default_nettype none

`include "ps2_mouse_settings.svh"

package mouse_reg_pkg;

  localparam logic [`MOUSE_ADDR_W-1:0] REG_STATUS   = 'h0;
  localparam logic [`MOUSE_ADDR_W-1:0] REG_PACKET   = 'h4;
  localparam logic [`MOUSE_ADDR_W-1:0] REG_MOTION   = 'h8;
  localparam logic [`MOUSE_ADDR_W-1:0] REG_CMD_RESP = 'hC;

  // status bit positions.
  localparam int PKT_VALID  = 0;
  localparam int RESP_VALID = 1;
  localparam int TX_BUSY    = 2;
  localparam int TX_ERR     = 3;
  localparam int RX_ERR     = 4;
  localparam int BTN_LSB    = 5;
  localparam int BTN_MSB    = 7;
  localparam int X_OVF      = 8;
  localparam int Y_OVF      = 9;

  typedef struct packed {
    logic [7:0] byte0;
    logic [7:0] byte1;
    logic [7:0] byte2;
  } mouse_raw_t;

  // byte0 bit order as sent by the device.
  typedef struct packed {
    logic       y_ovf;
    logic       x_ovf;
    logic       y_sign;
    logic       x_sign;
    logic       always_one;
    logic       middle;
    logic       right;
    logic       left;
    logic [7:0] x;
    logic [7:0] y;
  } mouse_motion_t;

  typedef union packed {
    mouse_raw_t    raw;
    mouse_motion_t mot;
  } mouse_packet_u;

endpackage

`default_nettype wire

// ==== design/ps2_frame_pkg.sv ====
`default_nettype none

package ps2_frame_pkg;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_INHIBIT,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP,
    TX_ACK
  } tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

endpackage

`default_nettype wire

// ==== design/ps2_mouse_settings.svh ====
`ifndef PS2_MOUSE_SETTINGS_SVH
`define PS2_MOUSE_SETTINGS_SVH

// host holds the device clock low this long before the start bit.
`define PS2_INHIBIT_CYCLES 200

// mid-frame stall limit, in system cycles.
`define PS2_TIMEOUT_CYCLES 4000

`define MOUSE_ADDR_W 4

`endif
